//--- source/lsb_pkg.sv
package lsb_pkg;

    localparam int XLEN           = 32;
    localparam int ROB_ID_W       = 4;
    localparam int LSB_DEPTH_LOG2 = 3;
    localparam int LSB_DEPTH      = 1 << LSB_DEPTH_LOG2;
    localparam int BYTE_CNT_W     = 2;
    localparam int FUNCT3_W       = 3;

    // load/store size codes from the instruction funct3 field
    localparam logic [FUNCT3_W-1:0] F3_B  = 3'd0;
    localparam logic [FUNCT3_W-1:0] F3_H  = 3'd1;
    localparam logic [FUNCT3_W-1:0] F3_W  = 3'd2;
    localparam logic [FUNCT3_W-1:0] F3_BU = 3'd4;
    localparam logic [FUNCT3_W-1:0] F3_HU = 3'd5;

    // tag 0 means the operand is already available
    typedef logic [ROB_ID_W-1:0]       rob_id_t;
    typedef logic [LSB_DEPTH_LOG2-1:0] lsb_idx_t;

    typedef struct packed {
        logic                valid;
        logic                is_store;
        logic [FUNCT3_W-1:0] funct3;
        rob_id_t             rob_id;
        rob_id_t             q1;
        rob_id_t             q2;
        logic [XLEN-1:0]     v1;
        logic [XLEN-1:0]     v2;
        logic [XLEN-1:0]     imm;
    } lsb_issue_t;

    typedef struct packed {
        logic            valid;
        rob_id_t         rob_id;
        logic [XLEN-1:0] value;
    } lsb_cdb_t;

    typedef struct packed {
        logic            req;
        logic            wr;
        logic [XLEN-1:0] addr;
        logic [7:0]      wdata;
    } lsb_mem_req_t;

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        FINISH
    } lsb_state_e;

endpackage

//--- source/lsb_entry_queue.sv
`timescale 1ns/1ns

module lsb_entry_queue (
    input  logic                clk_in,
    input  logic                rst_in,
    input  logic                flush_in,
    input  lsb_pkg::lsb_issue_t issue_in,
    input  lsb_pkg::lsb_cdb_t   cdb_in,
    input  lsb_pkg::lsb_cdb_t   commit_in,
    input  logic                pop,
    output lsb_pkg::lsb_issue_t head,
    output logic                head_ready,
    output logic                full
);

    lsb_pkg::lsb_issue_t              entries [lsb_pkg::LSB_DEPTH];
    logic [lsb_pkg::LSB_DEPTH-1:0]    committed;
    logic [lsb_pkg::LSB_DEPTH-1:0]    commit_hit;
    lsb_pkg::lsb_idx_t                head_ptr;
    lsb_pkg::lsb_idx_t                tail_ptr;
    lsb_pkg::lsb_idx_t                head_next;
    logic [lsb_pkg::LSB_DEPTH_LOG2:0] count;
    // entries from head through the youngest committed store
    logic [lsb_pkg::LSB_DEPTH_LOG2:0] keep_cnt;
    logic [lsb_pkg::LSB_DEPTH_LOG2:0] keep_next;
    logic                             push;
    lsb_pkg::lsb_issue_t              incoming;

    function automatic logic tag_hit(lsb_pkg::rob_id_t tag, lsb_pkg::lsb_cdb_t cdb);
        return cdb.valid && (tag != '0) && (tag == cdb.rob_id);
    endfunction

    // issue is dropped on flush, it belongs to the squashed path
    assign push      = issue_in.valid && !full && !flush_in;
    assign head_next = head_ptr + {{(lsb_pkg::LSB_DEPTH_LOG2-1){1'b0}}, pop};

    // same-cycle wakeup of the entry being written
    always_comb begin
        incoming = issue_in;
        if (tag_hit(issue_in.q1, cdb_in)) begin
            incoming.q1 = '0;
            incoming.v1 = cdb_in.value;
        end
        if (tag_hit(issue_in.q2, cdb_in)) begin
            incoming.q2 = '0;
            incoming.v2 = cdb_in.value;
        end
    end

    always_comb begin
        lsb_pkg::lsb_idx_t offset;
        keep_next  = keep_cnt;
        commit_hit = '0;
        for (int i = 0; i < lsb_pkg::LSB_DEPTH; i++) begin
            offset = lsb_pkg::lsb_idx_t'(i) - head_ptr;
            if (commit_in.valid && ({1'b0, offset} < count) && entries[i].is_store &&
                entries[i].rob_id == commit_in.rob_id) begin
                commit_hit[i] = 1'b1;
                keep_next     = {1'b0, offset} + 1'b1;
            end
        end
        if (pop && keep_next != '0) begin
            keep_next = keep_next - 1'b1;
        end
    end

    always_ff @(posedge clk_in) begin
        for (int i = 0; i < lsb_pkg::LSB_DEPTH; i++) begin
            if (tag_hit(entries[i].q1, cdb_in)) begin
                entries[i].q1 <= '0;
                entries[i].v1 <= cdb_in.value;
            end
            if (tag_hit(entries[i].q2, cdb_in)) begin
                entries[i].q2 <= '0;
                entries[i].v2 <= cdb_in.value;
            end
        end
        if (push) begin
            entries[tail_ptr] <= incoming;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            head_ptr  <= '0;
            tail_ptr  <= '0;
            count     <= '0;
            keep_cnt  <= '0;
            committed <= '0;
        end else begin
            head_ptr  <= head_next;
            keep_cnt  <= keep_next;
            committed <= committed | commit_hit;
            if (flush_in) begin
                // committed stores survive, everything younger goes
                tail_ptr <= head_next + keep_next[lsb_pkg::LSB_DEPTH_LOG2-1:0];
                count    <= keep_next;
            end else begin
                if (push) begin
                    tail_ptr            <= tail_ptr + 1'b1;
                    committed[tail_ptr] <= 1'b0;
                end
                count <= count + {{lsb_pkg::LSB_DEPTH_LOG2{1'b0}}, push}
                               - {{lsb_pkg::LSB_DEPTH_LOG2{1'b0}}, pop};
            end
        end
    end

    assign head       = entries[head_ptr];
    assign full       = (count == lsb_pkg::LSB_DEPTH);
    assign head_ready = (count != '0) && (head.q1 == '0) &&
                        (!head.is_store || (head.q2 == '0 && committed[head_ptr]));

    // sequencer only retires what is queued
    assert property (@(posedge clk_in) disable iff (rst_in) pop |-> count != '0);

    // never overfilled, committed span stays inside the queue
    assert property (@(posedge clk_in) disable iff (rst_in)
        count <= lsb_pkg::LSB_DEPTH && keep_cnt <= count);

endmodule

//--- source/lsb_access_fsm.sv
`timescale 1ns/1ns

module lsb_access_fsm (
    input  logic                                clk_in,
    input  logic                                rst_in,
    input  logic                                flush_in,
    input  lsb_pkg::lsb_issue_t                 head,
    input  logic                                head_ready,
    input  logic                                mem_gnt_in,
    input  logic                                last_byte,
    input  logic [lsb_pkg::BYTE_CNT_W-1:0]      byte_idx,
    output lsb_pkg::lsb_state_e                 state,
    output logic                                pop,
    output logic                                capture,
    output logic [lsb_pkg::BYTE_CNT_W-1:0]      byte_idx_d,
    output lsb_pkg::lsb_mem_req_t               mem_out,
    output logic                                load_done
);

    // final byte granted, waiting for its read data
    logic last_sent;
    logic granted;
    logic abandon;

    assign granted = mem_out.req && mem_gnt_in;
    // committed stores are never cancelled
    assign abandon = flush_in && !head.is_store;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state     <= lsb_pkg::IDLE;
            last_sent <= 1'b0;
            capture   <= 1'b0;
        end else begin
            capture <= granted && !head.is_store;
            case (state)
                lsb_pkg::IDLE: begin
                    if (head_ready && !flush_in) begin
                        state <= lsb_pkg::ACCESS;
                    end
                end
                lsb_pkg::ACCESS: begin
                    if (abandon) begin
                        state     <= lsb_pkg::IDLE;
                        last_sent <= 1'b0;
                    end else if (last_sent) begin
                        state     <= lsb_pkg::FINISH;
                        last_sent <= 1'b0;
                    end else if (granted && last_byte) begin
                        last_sent <= 1'b1;
                    end
                end
                default: state <= lsb_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        byte_idx_d <= byte_idx;
    end

    always_comb begin
        mem_out.req   = (state == lsb_pkg::ACCESS) && !last_sent;
        mem_out.wr    = head.is_store;
        mem_out.addr  = head.v1 + head.imm +
                        {{(lsb_pkg::XLEN-lsb_pkg::BYTE_CNT_W){1'b0}}, byte_idx};
        // lsb first
        mem_out.wdata = head.v2[8*byte_idx +: 8];
    end

    assign pop       = (state == lsb_pkg::FINISH) && !abandon;
    assign load_done = (state == lsb_pkg::FINISH) && !head.is_store && !flush_in;

    // back-pressure: request and its payload hold until granted
    assert property (@(posedge clk_in) disable iff (rst_in)
        mem_out.req && !mem_gnt_in && !flush_in |=> mem_out.req && $stable(mem_out));

endmodule

//--- source/lsb_byte_counter.sv
`timescale 1ns/1ns

module lsb_byte_counter (
    input  logic                                clk_in,
    input  logic                                rst_in,
    input  lsb_pkg::lsb_state_e                 state,
    input  logic [lsb_pkg::FUNCT3_W-1:0]        funct3,
    input  logic                                step,
    output logic [lsb_pkg::BYTE_CNT_W-1:0]      byte_idx,
    output logic                                last_byte
);

    logic [lsb_pkg::BYTE_CNT_W-1:0] term;

    // last byte index per access size
    always_comb begin
        case (funct3)
            lsb_pkg::F3_B, lsb_pkg::F3_BU: term = 2'd0;
            lsb_pkg::F3_H, lsb_pkg::F3_HU: term = 2'd1;
            default:                       term = 2'd3;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (rst_in || state != lsb_pkg::ACCESS) begin
            byte_idx <= '0;
        end else if (step && !last_byte) begin
            byte_idx <= byte_idx + 1'b1;
        end
    end

    assign last_byte = (byte_idx == term);

    assert property (@(posedge clk_in) disable iff (rst_in) byte_idx <= term);

endmodule

//--- source/lsb_load_assembler.sv
`timescale 1ns/1ns

module lsb_load_assembler (
    input  logic                                clk_in,
    input  logic                                rst_in,
    input  logic                                capture,
    input  logic [lsb_pkg::BYTE_CNT_W-1:0]      byte_idx_d,
    input  logic [7:0]                          mem_rdata_in,
    input  logic [lsb_pkg::FUNCT3_W-1:0]        funct3,
    output logic [lsb_pkg::XLEN-1:0]            load_value
);

    logic [lsb_pkg::XLEN-1:0] raw;

    // each read byte lands in its own lane
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            raw <= '0;
        end else if (capture) begin
            raw[8*byte_idx_d +: 8] <= mem_rdata_in;
        end
    end

    always_comb begin
        case (funct3)
            lsb_pkg::F3_B: begin
                load_value = {{24{raw[7]}}, raw[7:0]};
            end
            lsb_pkg::F3_H: begin
                load_value = {{16{raw[15]}}, raw[15:0]};
            end
            lsb_pkg::F3_BU: begin
                load_value = {24'd0, raw[7:0]};
            end
            lsb_pkg::F3_HU: begin
                load_value = {16'd0, raw[15:0]};
            end
            // word and anything unexpected pass through
            default: begin
                load_value = raw;
            end
        endcase
    end

endmodule

//--- source/load_store_buffer.sv
`timescale 1ns/1ns

module load_store_buffer (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  logic                  flush_in,
    input  lsb_pkg::lsb_issue_t   issue_in,
    output logic                  full,
    input  lsb_pkg::lsb_cdb_t     cdb_in,
    input  lsb_pkg::lsb_cdb_t     commit_in,
    output lsb_pkg::lsb_mem_req_t mem_out,
    input  logic                  mem_gnt_in,
    input  logic [7:0]            mem_rdata_in,
    output lsb_pkg::lsb_cdb_t     result_out
);

    lsb_pkg::lsb_issue_t              head;
    lsb_pkg::lsb_state_e              state;
    logic                             head_ready;
    logic                             pop;
    logic                             capture;
    logic                             step;
    logic                             last_byte;
    logic                             load_done;
    logic [lsb_pkg::BYTE_CNT_W-1:0]   byte_idx;
    logic [lsb_pkg::BYTE_CNT_W-1:0]   byte_idx_d;
    logic [lsb_pkg::XLEN-1:0]         load_value;

    // one byte moves per granted request
    assign step = mem_out.req && mem_gnt_in;

    lsb_entry_queue lsb_entry_queue_inst (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .flush_in   (flush_in),
        .issue_in   (issue_in),
        .cdb_in     (cdb_in),
        .commit_in  (commit_in),
        .pop        (pop),
        .head       (head),
        .head_ready (head_ready),
        .full       (full)
    );

    lsb_access_fsm lsb_access_fsm_inst (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .flush_in   (flush_in),
        .head       (head),
        .head_ready (head_ready),
        .mem_gnt_in (mem_gnt_in),
        .last_byte  (last_byte),
        .byte_idx   (byte_idx),
        .state      (state),
        .pop        (pop),
        .capture    (capture),
        .byte_idx_d (byte_idx_d),
        .mem_out    (mem_out),
        .load_done  (load_done)
    );

    lsb_byte_counter lsb_byte_counter_inst (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .state     (state),
        .funct3    (head.funct3),
        .step      (step),
        .byte_idx  (byte_idx),
        .last_byte (last_byte)
    );

    lsb_load_assembler lsb_load_assembler_inst (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .capture      (capture),
        .byte_idx_d   (byte_idx_d),
        .mem_rdata_in (mem_rdata_in),
        .funct3       (head.funct3),
        .load_value   (load_value)
    );

    // head still holds the load while FINISH is up
    always_comb begin
        result_out.valid  = load_done;
        result_out.rob_id = head.rob_id;
        result_out.value  = load_value;
    end

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk_in,
    output logic rst_in
);

    localparam int HALF_PERIOD_NS = 2;
    localparam int RESET_CYCLES   = 4;

    initial begin
        clk_in = 1'b0;
        forever #(HALF_PERIOD_NS) clk_in = ~clk_in;
    end

    // reset drops just after the last reset edge
    initial begin
        rst_in = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_in);
        #1 rst_in = 1'b0;
    end

endmodule

//--- tests/load_store_buffer_tb.sv
`timescale 1ns/1ns

module load_store_buffer_tb;

    localparam int PERIOD_NS     = 4;
    localparam int MAX_ROWS      = 64;
    localparam int K_ISSUE       = 0;
    localparam int K_ISSUE_BCAST = 1;
    localparam int K_BCAST       = 2;
    localparam int K_COMMIT      = 3;
    localparam int K_FLUSH       = 4;
    localparam int K_IDLE        = 5;
    localparam int K_DRAIN       = 6;
    localparam int K_FULL        = 7;

    typedef struct packed {
        logic [2:0]                   kind;
        logic                         is_store;
        logic [lsb_pkg::FUNCT3_W-1:0] funct3;
        lsb_pkg::rob_id_t             rob_id;
        lsb_pkg::rob_id_t             q1;
        lsb_pkg::rob_id_t             q2;
        logic [lsb_pkg::XLEN-1:0]     v1;
        logic [lsb_pkg::XLEN-1:0]     v2;
        logic [lsb_pkg::XLEN-1:0]     imm;
        logic [lsb_pkg::XLEN-1:0]     exp_value;
        logic                         drop;
    } stim_row_t;

    logic                  clk_in;
    logic                  rst_in;
    logic                  flush_in;
    lsb_pkg::lsb_issue_t   issue_in;
    logic                  full;
    lsb_pkg::lsb_cdb_t     cdb_in;
    lsb_pkg::lsb_cdb_t     commit_in;
    lsb_pkg::lsb_mem_req_t mem_out;
    logic                  mem_gnt_in;
    logic [7:0]            mem_rdata_in;
    lsb_pkg::lsb_cdb_t     result_out;

    logic [7:0]        mem [256];
    logic [7:0]        ref_mem [256];
    logic [7:0]        read_byte;
    stim_row_t         table_rows [MAX_ROWS];
    int                n_rows;
    lsb_pkg::lsb_cdb_t exp_q [$];
    int                bytes_owed;
    int                store_size [16];
    lsb_pkg::rob_id_t  waiting_tag;
    integer            seed;
    bit                table_ready;

    tb_clock_gen tb_clock_gen_inst (.clk_in(clk_in), .rst_in(rst_in));

    load_store_buffer load_store_buffer_inst (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .flush_in     (flush_in),
        .issue_in     (issue_in),
        .full         (full),
        .cdb_in       (cdb_in),
        .commit_in    (commit_in),
        .mem_out      (mem_out),
        .mem_gnt_in   (mem_gnt_in),
        .mem_rdata_in (mem_rdata_in),
        .result_out   (result_out)
    );

    function automatic logic [7:0] fill_byte(int addr);
        return 8'(addr * 37 + 129) ^ 8'(addr >> 3);
    endfunction

    function automatic int access_bytes(logic [2:0] f3);
        if (f3 == lsb_pkg::F3_B || f3 == lsb_pkg::F3_BU) return 1;
        if (f3 == lsb_pkg::F3_H || f3 == lsb_pkg::F3_HU) return 2;
        return 4;
    endfunction

    // RV32 load rules applied to the reference memory
    function automatic logic [31:0] load_expect(logic [31:0] addr, logic [2:0] f3);
        logic [31:0] w;
        w = {ref_mem[8'(addr + 3)], ref_mem[8'(addr + 2)], ref_mem[8'(addr + 1)],
             ref_mem[8'(addr)]};
        case (f3)
            lsb_pkg::F3_B:  return {{24{w[7]}}, w[7:0]};
            lsb_pkg::F3_H:  return {{16{w[15]}}, w[15:0]};
            lsb_pkg::F3_BU: return {24'd0, w[7:0]};
            lsb_pkg::F3_HU: return {16'd0, w[15:0]};
            default:        return w;
        endcase
    endfunction

    task automatic ref_store(input logic [31:0] addr, input logic [2:0] f3,
                             input logic [31:0] data);
        for (int k = 0; k < access_bytes(f3); k++) begin
            ref_mem[8'(addr + 32'(k))] = data[8*k +: 8];
        end
    endtask

    // loads carry their eventual base in v2 when q1 is pending
    task automatic add_row(input int kind, input logic st, input logic [2:0] f3,
                           input int rob, input int q1, input logic [31:0] v1,
                           input logic [31:0] v2, input logic [31:0] imm, input logic drop);
        stim_row_t r;
        r = '0;
        r.kind = 3'(kind);
        r.is_store = st;
        r.funct3 = f3;
        r.rob_id = 4'(rob);
        r.q1 = 4'(q1);
        r.v1 = v1;
        r.v2 = v2;
        r.imm = imm;
        r.drop = drop;
        if ((kind == K_ISSUE || kind == K_ISSUE_BCAST) && !st) begin
            r.exp_value = load_expect(((q1 != 0) ? v2 : v1) + imm, f3);
        end
        if (kind == K_ISSUE && st && q1 == 0) begin
            ref_store(v1 + imm, f3, v2);
        end
        table_rows[n_rows] = r;
        n_rows++;
    endtask

    task automatic add_ctrl(input int kind, input int rob, input logic [31:0] value);
        add_row(kind, 1'b0, 3'd0, rob, 0, value, 32'd0, 32'd0, 1'b0);
    endtask

    task automatic build_table();
        logic [2:0] f3_list [5];
        f3_list = '{lsb_pkg::F3_B, lsb_pkg::F3_H, lsb_pkg::F3_W, lsb_pkg::F3_BU, lsb_pkg::F3_HU};
        n_rows = 0;
        for (int a = 0; a < 256; a++) begin
            ref_mem[a] = fill_byte(a);
        end
        // every load size, base wraps past the 256-byte model
        for (int j = 0; j < 2; j++) begin
            for (int i = 0; i < 5; i++) begin
                add_row(K_ISSUE, 1'b0, f3_list[i], 1 + i + 5 * j, 0,
                        32'h100 + 32'(i * 24 + j * 69), 32'd0, 32'(i + 7), 1'b0);
            end
        end
        add_ctrl(K_DRAIN, 0, 0);
        // wakeup by later broadcast, then same-cycle bypass
        add_row(K_ISSUE, 1'b0, lsb_pkg::F3_W, 2, 7, 32'hdead_beef, 32'h60, 32'd4, 1'b0);
        for (int i = 0; i < 3; i++) begin
            add_ctrl(K_IDLE, 0, 0);
        end
        add_ctrl(K_BCAST, 7, 32'h60);
        add_row(K_ISSUE_BCAST, 1'b0, lsb_pkg::F3_H, 3, 9, 32'hdead_beef, 32'h71, 32'd2, 1'b0);
        add_ctrl(K_DRAIN, 0, 0);
        // stores held until commit, then read back
        add_row(K_ISSUE, 1'b1, lsb_pkg::F3_W, 4, 0, 32'h80, 32'ha5c3_1e7f, 32'd0, 1'b0);
        for (int i = 0; i < 4; i++) begin
            add_ctrl(K_IDLE, 0, 0);
        end
        add_ctrl(K_COMMIT, 4, 0);
        add_row(K_ISSUE, 1'b1, lsb_pkg::F3_H, 5, 0, 32'h90, 32'h0000_8421, 32'd1, 1'b0);
        add_row(K_ISSUE, 1'b1, lsb_pkg::F3_B, 6, 0, 32'h94, 32'h0000_00f0, 32'd0, 1'b0);
        add_ctrl(K_COMMIT, 5, 0);
        add_ctrl(K_COMMIT, 6, 0);
        add_row(K_ISSUE, 1'b0, lsb_pkg::F3_W, 7, 0, 32'h80, 32'd0, 32'd0, 1'b0);
        add_row(K_ISSUE, 1'b0, lsb_pkg::F3_HU, 8, 0, 32'h90, 32'd0, 32'd1, 1'b0);
        add_row(K_ISSUE, 1'b0, lsb_pkg::F3_B, 10, 0, 32'h94, 32'd0, 32'd0, 1'b0);
        add_ctrl(K_DRAIN, 0, 0);
        // uncommitted store at the head lets the queue fill
        add_row(K_ISSUE, 1'b1, lsb_pkg::F3_W, 1, 0, 32'ha0, 32'h1357_9bdf, 32'd0, 1'b0);
        for (int i = 0; i < 7; i++) begin
            add_row(K_ISSUE, 1'b0, f3_list[i % 5], i + 2, 0, 32'h9e, 32'd0, 32'(i), 1'b0);
        end
        add_ctrl(K_FULL, 0, 1);
        add_ctrl(K_COMMIT, 1, 0);
        add_ctrl(K_DRAIN, 0, 0);
        add_ctrl(K_FULL, 0, 0);
        // committed store survives the flush, loads behind it do not
        add_row(K_ISSUE, 1'b1, lsb_pkg::F3_H, 11, 12, 32'hdead_beef, 32'h0000_beef, 32'd0, 1'b0);
        ref_store(32'hc0, lsb_pkg::F3_H, 32'h0000_beef);
        add_ctrl(K_COMMIT, 11, 0);
        add_row(K_ISSUE, 1'b0, lsb_pkg::F3_W, 13, 0, 32'hc0, 32'd0, 32'd0, 1'b1);
        add_row(K_ISSUE, 1'b0, lsb_pkg::F3_B, 14, 0, 32'h20, 32'd0, 32'd0, 1'b1);
        add_ctrl(K_FLUSH, 0, 0);
        add_ctrl(K_BCAST, 12, 32'hc0);
        add_row(K_ISSUE, 1'b0, lsb_pkg::F3_HU, 15, 0, 32'hc0, 32'd0, 32'd0, 1'b0);
        add_ctrl(K_DRAIN, 0, 0);
    endtask

    task automatic stop_run();
        $display("TEST FAIL");
        $fatal(1, "load_store_buffer_tb stopped on the first failure");
    endtask

    task automatic check_result(input lsb_pkg::lsb_cdb_t got, input lsb_pkg::lsb_cdb_t exp);
        if (got !== exp) begin
            $display("[ERROR] result_out: got rob_id %h value %h, expected rob_id %h value %h",
                     got.rob_id, got.value, exp.rob_id, exp.value);
            stop_run();
        end
    endtask

    task automatic check_mem_byte(input int addr, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("[ERROR] mem[%h]: got %h, expected %h", addr, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic fail_plain(input string msg);
        $display("%s", msg);
        stop_run();
    endtask

    // done once nothing is owed and the port stays quiet
    task automatic drain();
        int quiet;
        quiet = 0;
        while (quiet < 4) begin
            @(posedge clk_in);
            #1;
            if (exp_q.size() == 0 && bytes_owed == 0 && !mem_out.req) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
    endtask

    task automatic apply_row(input stim_row_t r);
        case (int'(r.kind))
            K_ISSUE, K_ISSUE_BCAST: begin
                while (full) begin
                    @(posedge clk_in);
                    #1;
                end
                issue_in = {1'b1, r.is_store, r.funct3, r.rob_id, r.q1, r.q2, r.v1, r.v2, r.imm};
                if (r.kind == 3'(K_ISSUE_BCAST)) begin
                    cdb_in = {1'b1, r.q1, r.v2};
                end else if (r.q1 != '0) begin
                    waiting_tag = r.q1;
                end
                if (r.is_store) begin
                    store_size[r.rob_id] = access_bytes(r.funct3);
                end else if (!r.drop) begin
                    exp_q.push_back({1'b1, r.rob_id, r.exp_value});
                end
            end
            K_BCAST: begin
                cdb_in = {1'b1, r.rob_id, r.v1};
                if (waiting_tag == r.rob_id) begin
                    waiting_tag = '0;
                end
            end
            K_COMMIT: begin
                commit_in = {1'b1, r.rob_id, 32'd0};
                bytes_owed += store_size[r.rob_id];
            end
            K_FLUSH: flush_in = 1'b1;
            K_DRAIN: drain();
            K_FULL:  check_flag("full", full, r.v1[0]);
            default: ;
        endcase
    endtask

    // byte-wide memory, read data one cycle after grant
    always @(posedge clk_in) begin
        if (!rst_in && mem_out.req && mem_gnt_in) begin
            if (waiting_tag != '0) begin
                fail_plain("memory was accessed before the wakeup broadcast");
            end else if (mem_out.wr) begin
                if (bytes_owed == 0) begin
                    fail_plain("a store wrote memory before it was committed");
                end else begin
                    bytes_owed--;
                    mem[mem_out.addr[7:0]] = mem_out.wdata;
                end
            end else begin
                read_byte = mem[mem_out.addr[7:0]];
                #1;
                mem_rdata_in = read_byte;
            end
        end
    end

    always @(posedge clk_in) begin
        #1;
        mem_gnt_in = (($random(seed) & 32'h3) != 0);
    end

    always @(negedge clk_in) begin
        if (!rst_in && result_out.valid) begin
            if (exp_q.size() == 0) begin
                fail_plain("a load result appeared with no load outstanding");
            end else begin
                check_result(result_out, exp_q.pop_front());
            end
        end
    end

    initial begin
        wait (table_ready);
        #((n_rows * 40 + 200) * PERIOD_NS);
        fail_plain("timeout: the run did not finish in the expected time");
    end

    initial begin
        flush_in     = 1'b0;
        issue_in     = '0;
        cdb_in       = '0;
        commit_in    = '0;
        mem_gnt_in   = 1'b0;
        mem_rdata_in = 8'd0;
        bytes_owed   = 0;
        waiting_tag  = '0;
        seed         = 73;
        for (int a = 0; a < 256; a++) begin
            mem[a] = fill_byte(a);
        end
        build_table();
        table_ready = 1'b1;
        @(negedge rst_in);
        for (int i = 0; i < n_rows; i++) begin
            @(posedge clk_in);
            #1;
            issue_in  = '0;
            cdb_in    = '0;
            commit_in = '0;
            flush_in  = 1'b0;
            apply_row(table_rows[i]);
        end
        @(posedge clk_in);
        #1;
        issue_in  = '0;
        cdb_in    = '0;
        commit_in = '0;
        flush_in  = 1'b0;
        drain();
        for (int a = 0; a < 256; a++) begin
            check_mem_byte(a, mem[a], ref_mem[a]);
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- vlog.f
source/lsb_pkg.sv
source/lsb_entry_queue.sv
source/lsb_access_fsm.sv
source/lsb_byte_counter.sv
source/lsb_load_assembler.sv
source/load_store_buffer.sv
tests/tb_clock_gen.sv
tests/load_store_buffer_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= load_store_buffer_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(BUILD_DIR)
